// ==== hdl/concat_pkg.sv ====
// stream concatenator definitions

package concat_pkg;

    // byte lanes per beat
    localparam int lanes = 4;

    localparam int byte_w = 8;

    localparam int data_w = lanes * byte_w;

    localparam int id_w = 8;

    // lane offset and byte count widths
    localparam int off_w = $clog2(lanes);
    localparam int cnt_w = off_w + 1;

    // one beat of a stream
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [lanes-1:0]  keep;
        logic              last;
        logic [id_w-1:0]   id;
    } beat_t;

endpackage

// ==== hdl/stream_skid_buf.sv ====
// stream skid buffer

`timescale 1ns/10ps

module stream_skid_buf (
    input  logic              clk,
    input  logic              rst,

    input  concat_pkg::beat_t s_beat,
    input  logic              s_valid,
    output logic              s_ready,

    output concat_pkg::beat_t m_beat,
    output logic              m_valid,
    input  logic              m_ready
);

    concat_pkg::beat_t out_q;
    concat_pkg::beat_t tmp_q;

    logic out_valid_q;
    logic out_valid_d;
    logic tmp_valid_q;
    logic tmp_valid_d;
    logic ready_q;
    logic ready_d;

    logic in_to_out;
    logic in_to_tmp;
    logic tmp_to_out;

    assign s_ready = ready_q;
    assign m_beat  = out_q;
    assign m_valid = out_valid_q;

    // room next cycle unless the temp entry is about to fill
    assign ready_d = m_ready || (!tmp_valid_q && (!out_valid_q || !s_valid));

    always_comb begin
        out_valid_d = out_valid_q;
        tmp_valid_d = tmp_valid_q;
        in_to_out   = 1'b0;
        in_to_tmp   = 1'b0;
        tmp_to_out  = 1'b0;

        if (ready_q) begin
            if (m_ready || !out_valid_q) begin
                out_valid_d = s_valid;
                in_to_out   = 1'b1;
            end else begin
                // park the beat while the sink stalls
                tmp_valid_d = s_valid;
                in_to_tmp   = 1'b1;
            end
        end else if (m_ready) begin
            out_valid_d = tmp_valid_q;
            tmp_valid_d = 1'b0;
            tmp_to_out  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
            tmp_valid_q <= 1'b0;
            ready_q     <= 1'b0;
        end else begin
            out_valid_q <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
            ready_q     <= ready_d;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_q <= s_beat;
        end else if (tmp_to_out) begin
            out_q <= tmp_q;
        end

        if (in_to_tmp) begin
            tmp_q <= s_beat;
        end
    end

endmodule

// ==== hdl/concat_port_seq.sv ====
// input port sequencer

`timescale 1ns/10ps

module concat_port_seq #(
    parameter int S_COUNT = 4
) (
    input  logic               clk,
    input  logic               rst,

    input  concat_pkg::beat_t  buf_beat [S_COUNT],
    input  logic [S_COUNT-1:0] buf_valid,
    output logic [S_COUNT-1:0] buf_ready,

    output concat_pkg::beat_t  sel_beat,
    output logic               sel_valid,
    output logic               sel_final,
    input  logic               sel_accept
);

    localparam int sel_w = $clog2(S_COUNT);

    logic [sel_w-1:0] sel_q;
    logic             last_port;
    logic             take;

    // selected buffer onto the single path
    assign sel_beat  = buf_beat[sel_q];
    assign sel_valid = buf_valid[sel_q];

    assign last_port = (sel_q == sel_w'(S_COUNT - 1));

    // frame ends with the last beat of the last port
    assign sel_final = sel_beat.last && last_port;

    assign take = sel_valid && sel_accept;

    // ready only to the selected buffer
    always_comb begin
        buf_ready = '0;
        for (int n = 0; n < S_COUNT; n++) begin
            if (sel_q == sel_w'(n)) begin
                buf_ready[n] = sel_accept;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= '0;
        end else if (take && sel_beat.last) begin
            // step to the next port and wrap back to port 0
            if (last_port) begin
                sel_q <= '0;
            end else begin
                sel_q <= sel_q + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/concat_byte_repack.sv ====
// byte repacker for concatenated frames

`timescale 1ns/10ps

module concat_byte_repack (
    input  logic              clk,
    input  logic              rst,

    input  concat_pkg::beat_t sel_beat,
    input  logic              sel_valid,
    input  logic              sel_final,
    output logic              sel_accept,

    output concat_pkg::beat_t pk_beat,
    output logic              pk_valid,
    input  logic              pk_ready
);

    localparam int lanes  = concat_pkg::lanes;
    localparam int byte_w = concat_pkg::byte_w;
    localparam int data_w = concat_pkg::data_w;
    localparam int off_w  = concat_pkg::off_w;
    localparam int cnt_w  = concat_pkg::cnt_w;

    // two-word shift buffer with the low word at the bottom
    logic [2*data_w-1:0]        data_q;
    logic [2*data_w-1:0]        data_d;
    logic [2*lanes-1:0]         keep_q;
    logic [2*lanes-1:0]         keep_d;
    logic [1:0]                 last_q;
    logic [1:0]                 last_d;
    logic [concat_pkg::id_w-1:0] id_q;
    logic [concat_pkg::id_w-1:0] id_d;
    logic [off_w-1:0]           offset_q;
    logic [off_w-1:0]           offset_d;

    logic [cnt_w-1:0] byte_cnt;
    logic             take;
    logic             shift;

    // low word leaves once full or closing the frame
    assign pk_valid = keep_q[lanes-1] || last_q[0];
    assign shift    = pk_valid && pk_ready;

    assign pk_beat.data = data_q[data_w-1:0];
    assign pk_beat.keep = keep_q[lanes-1:0];
    assign pk_beat.last = last_q[0];
    assign pk_beat.id   = id_q;

    // hold off while a spilled final word waits or the output stalls
    assign sel_accept = !last_q[1] && !(pk_valid && !pk_ready);
    assign take       = sel_valid && sel_accept;

    // highest set keep lane plus one
    always_comb begin
        byte_cnt = '0;
        for (int k = 0; k < lanes; k++) begin
            if (sel_beat.keep[k]) begin
                byte_cnt = cnt_w'(k + 1);
            end
        end
    end

    always_comb begin
        data_d   = data_q;
        keep_d   = keep_q;
        last_d   = last_q;
        id_d     = id_q;
        offset_d = offset_q;

        if (shift) begin
            data_d[data_w-1:0] = data_q[2*data_w-1:data_w];
            keep_d = {{lanes{1'b0}}, keep_q[2*lanes-1:lanes]};
            last_d = {1'b0, last_q[1]};
        end

        if (take) begin
            // place the beat at the running lane offset
            data_d[offset_q*byte_w +: data_w] = sel_beat.data;
            keep_d[offset_q +: lanes]         = sel_beat.keep;
            id_d     = sel_beat.id;
            offset_d = offset_q + off_w'(byte_cnt);

            if (sel_final) begin
                offset_d = '0;
                if (keep_d[2*lanes-1:lanes] != '0) begin
                    // a spill into the high word leaves two words
                    last_d[1] = 1'b1;
                end else begin
                    last_d[0] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            keep_q   <= '0;
            last_q   <= '0;
            offset_q <= '0;
        end else begin
            keep_q   <= keep_d;
            last_q   <= last_d;
            offset_q <= offset_d;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data_d;
        id_q   <= id_d;
    end

endmodule

// ==== hdl/concat_top.sv ====
// stream frame concatenator

`timescale 1ns/10ps

module concat_top #(
    parameter int S_COUNT = 4
) (
    input  logic               clk,
    input  logic               rst,

    input  concat_pkg::beat_t  in_beat [S_COUNT],
    input  logic [S_COUNT-1:0] in_valid,
    output logic [S_COUNT-1:0] in_ready,

    output concat_pkg::beat_t  out_beat,
    output logic               out_valid,
    input  logic               out_ready
);

    concat_pkg::beat_t  buf_beat [S_COUNT];
    logic [S_COUNT-1:0] buf_valid;
    logic [S_COUNT-1:0] buf_ready;

    concat_pkg::beat_t sel_beat;
    logic              sel_valid;
    logic              sel_final;
    logic              sel_accept;

    concat_pkg::beat_t pk_beat;
    logic              pk_valid;
    logic              pk_ready;

    // one buffer per input
    for (genvar n = 0; n < S_COUNT; n++) begin : g_in_buf
        stream_skid_buf u_in_buf (
            .clk     (clk),
            .rst     (rst),
            .s_beat  (in_beat[n]),
            .s_valid (in_valid[n]),
            .s_ready (in_ready[n]),
            .m_beat  (buf_beat[n]),
            .m_valid (buf_valid[n]),
            .m_ready (buf_ready[n])
        );
    end

    concat_port_seq #(
        .S_COUNT (S_COUNT)
    ) u_port_seq (
        .clk        (clk),
        .rst        (rst),
        .buf_beat   (buf_beat),
        .buf_valid  (buf_valid),
        .buf_ready  (buf_ready),
        .sel_beat   (sel_beat),
        .sel_valid  (sel_valid),
        .sel_final  (sel_final),
        .sel_accept (sel_accept)
    );

    concat_byte_repack u_repack (
        .clk        (clk),
        .rst        (rst),
        .sel_beat   (sel_beat),
        .sel_valid  (sel_valid),
        .sel_final  (sel_final),
        .sel_accept (sel_accept),
        .pk_beat    (pk_beat),
        .pk_valid   (pk_valid),
        .pk_ready   (pk_ready)
    );

    stream_skid_buf u_out_buf (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (pk_beat),
        .s_valid (pk_valid),
        .s_ready (pk_ready),
        .m_beat  (out_beat),
        .m_valid (out_valid),
        .m_ready (out_ready)
    );

endmodule

// ==== test/concat_chk.sv ====
// output stream assertions

`timescale 1ns/10ps

module concat_chk #(
    parameter int S_COUNT = 4
) (
    input logic               clk,
    input logic               rst,
    input logic [S_COUNT-1:0] in_ready,
    input concat_pkg::beat_t  out_beat,
    input logic               out_valid,
    input logic               out_ready
);

    logic [concat_pkg::lanes-1:0]  keep_inc;
    logic [concat_pkg::data_w-1:0] kept_data;

    assign keep_inc = out_beat.keep + 1'b1;

    // data of the kept lanes only
    always_comb begin
        kept_data = '0;
        for (int k = 0; k < concat_pkg::lanes; k++) begin
            if (out_beat.keep[k]) begin
                kept_data[k*concat_pkg::byte_w +: concat_pkg::byte_w] =
                    out_beat.data[k*concat_pkg::byte_w +: concat_pkg::byte_w];
            end
        end
    end

    // a stalled beat stays put
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(kept_data) &&
            $stable(out_beat.keep) && $stable(out_beat.last) && $stable(out_beat.id))
        else $error("out_beat changed or dropped while out_ready was low");

    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_beat.keep[0] && ((out_beat.keep & keep_inc) == '0))
        else $error("out_beat.keep is not contiguous from lane 0");

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_beat.last |-> &out_beat.keep)
        else $error("partial keep on a beat without last");

    assert property (@(posedge clk) rst |=> !out_valid && (in_ready == '0))
        else $error("out_valid or in_ready high after a reset cycle");

endmodule

bind concat_top concat_chk #(
    .S_COUNT (S_COUNT)
) u_chk (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

// ==== test/concat_tb.sv ====
// concatenator testbench

`timescale 1ns/10ps

module concat_tb;

    localparam int S_COUNT   = 4;
    localparam int lanes     = concat_pkg::lanes;
    localparam int byte_w    = concat_pkg::byte_w;
    localparam int id_w      = concat_pkg::id_w;
    localparam int max_beats = 4;

    // 27 rounds of up to 4 beats per input with gaps up to 3 cycles
    localparam int beat_slots  = 27 * S_COUNT * max_beats * 4;
    localparam int cycle_limit = 2 * beat_slots + 200;

    logic clk = 1'b0;
    logic rst = 1'b1;

    concat_pkg::beat_t  in_beat [S_COUNT];
    logic [S_COUNT-1:0] in_valid = '0;
    logic [S_COUNT-1:0] in_ready;
    concat_pkg::beat_t  out_beat;
    logic               out_valid;
    logic               out_ready = 1'b1;

    logic [31:0]     lfsr = 32'h0b9c_8b58;
    logic [31:0]     bp_lfsr = 32'h0b9c_8b58;
    logic [7:0]      exp_bytes [$];
    int              exp_len [$];
    logic [id_w-1:0] exp_id [$];

    int              frame_len [S_COUNT];
    logic [7:0]      frame_first [S_COUNT];
    logic [id_w-1:0] frame_id [S_COUNT];
    int              gap_tab [S_COUNT][max_beats];

    string           test_name = "";
    bit              checking = 1'b1;
    bit              abort = 1'b0;
    bit              bp_on = 1'b0;
    int              round_cnt = 0;
    int              cur_beats = 0;
    int              cur_rem = 0;
    int              cur_len = 0;
    logic [id_w-1:0] cur_id;
    int              exp_sel = 0;
    int              value_errs = 0;
    int              proto_errs = 0;
    int              beats_seen = 0;
    int              cycles = 0;

    concat_top #(
        .S_COUNT (S_COUNT)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #20 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic concat_pkg::beat_t make_beat(input int n, input int i);
        concat_pkg::beat_t b;
        int idx;
        b = '0;
        for (int k = 0; k < lanes; k++) begin
            idx = i * lanes + k;
            if (idx < frame_len[n]) begin
                b.data[k*byte_w +: byte_w] = frame_first[n] + 8'(idx);
                b.keep[k] = 1'b1;
            end else begin
                b.data[k*byte_w +: byte_w] = 8'hee;
            end
        end
        b.last = ((i + 1) * lanes >= frame_len[n]);
        b.id   = frame_id[n];
        return b;
    endfunction

    task automatic check_beat(input concat_pkg::beat_t exp, input concat_pkg::beat_t act);
        logic [concat_pkg::data_w-1:0] mask;
        logic id_ok;
        mask = '0;
        for (int k = 0; k < lanes; k++) begin
            if (exp.keep[k]) begin
                mask[k*byte_w +: byte_w] = '1;
            end
        end
        // id only matters on the closing beat
        id_ok = !exp.last || (exp.id == act.id);
        if (((exp.data & mask) != (act.data & mask)) || (exp.keep != act.keep) ||
            (exp.last != act.last) || !id_ok) begin
            value_errs++;
            $write("[FAIL] %s beat: expected data %h keep %b last %b id %h, ", test_name,
                   exp.data & mask, exp.keep, exp.last, exp.id);
            $display("actual data %h keep %b last %b id %h",
                     act.data & mask, act.keep, act.last, act.id);
        end
    endtask

    task automatic check_len(input int exp, input int act);
        if (exp != act) begin
            value_errs++;
            $display("[FAIL] %s frame length: expected %0d beats, actual %0d",
                     test_name, exp, act);
        end
    endtask

    task automatic take_output(input concat_pkg::beat_t act);
        concat_pkg::beat_t exp;
        int n;
        if (cur_beats == 0) begin
            if (exp_len.size() == 0) begin
                proto_errs++;
                $display("%s: an output beat arrived with no frame expected", test_name);
                return;
            end
            cur_len = exp_len.pop_front();
            cur_rem = cur_len;
            cur_id  = exp_id.pop_front();
        end
        n = (cur_rem < lanes) ? cur_rem : lanes;
        exp = '0;
        for (int k = 0; k < n; k++) begin
            exp.data[k*byte_w +: byte_w] = exp_bytes.pop_front();
            exp.keep[k] = 1'b1;
        end
        cur_rem  = cur_rem - n;
        exp.last = (cur_rem == 0);
        exp.id   = cur_id;
        cur_beats++;
        beats_seen++;
        check_beat(exp, act);
        // the output frame closes on the DUT's own last flag
        if (act.last) begin
            check_len((cur_len + lanes - 1) / lanes, cur_beats);
            for (int k = 0; k < cur_rem; k++) begin
                void'(exp_bytes.pop_front());
            end
            cur_beats = 0;
        end
    endtask

    task automatic build_frame(input int n, input int len);
        frame_len[n]   = len;
        frame_first[n] = 8'(rand_bits(8));
        frame_id[n]    = id_w'(round_cnt * S_COUNT + n);
        for (int j = 0; j < len; j++) begin
            exp_bytes.push_back(frame_first[n] + 8'(j));
        end
    endtask

    task automatic drive_input(input int n, input int delay);
        int nbeats;
        int i;
        nbeats = (frame_len[n] + lanes - 1) / lanes;
        i = 0;
        repeat (delay) @(posedge clk);
        while (i < nbeats && !abort) begin
            if (gap_tab[n][i] > 0) begin
                in_valid[n] <= 1'b0;
                repeat (gap_tab[n][i]) @(posedge clk);
            end
            in_beat[n]  <= make_beat(n, i);
            in_valid[n] <= 1'b1;
            do begin
                @(posedge clk);
            end while (!in_ready[n] && !abort);
            i++;
        end
        in_valid[n] <= 1'b0;
    endtask

    task automatic run_round(input int l0, input int l1, input int l2, input int l3,
                             input bit gaps, input bit reverse);
        int lens [S_COUNT];
        int total;
        lens  = '{l0, l1, l2, l3};
        total = 0;
        for (int n = 0; n < S_COUNT; n++) begin
            build_frame(n, lens[n]);
            total += lens[n];
            for (int i = 0; i < max_beats; i++) begin
                gap_tab[n][i] = gaps ? rand_bits(2) : 0;
            end
        end
        exp_len.push_back(total);
        exp_id.push_back(frame_id[S_COUNT-1]);
        round_cnt++;
        fork
            drive_input(0, reverse ? 18 : 0);
            drive_input(1, reverse ? 12 : 0);
            drive_input(2, reverse ? 6 : 0);
            drive_input(3, 0);
        join
        while ((exp_len.size() != 0 || cur_beats != 0) && !abort) begin
            @(posedge clk);
        end
    endtask

    task automatic whole_word_frames();
        test_name = "whole_words";
        run_round(8, 4, 12, 8, 1'b0, 1'b0);
    endtask

    task automatic partial_last_beats();
        test_name = "partial";
        run_round(5, 6, 7, 4, 1'b0, 1'b0);
        // final beats spilling one word past
        run_round(1, 1, 1, 3, 1'b0, 1'b0);
        run_round(3, 2, 2, 2, 1'b0, 1'b0);
    endtask

    task automatic reverse_valid_order();
        test_name = "reverse";
        run_round(4, 7, 5, 9, 1'b0, 1'b1);
    endtask

    task automatic random_rounds();
        int l [S_COUNT];
        test_name = "random";
        bp_on = 1'b1;
        repeat (20) begin
            for (int n = 0; n < S_COUNT; n++) begin
                l[n] = rand_bits(4) + 1;
            end
            run_round(l[0], l[1], l[2], l[3], 1'b1, 1'b0);
        end
        bp_on = 1'b0;
    endtask

    task automatic reset_mid_frame();
        test_name = "mid_reset";
        checking = 1'b0;
        fork
            run_round(16, 16, 16, 16, 1'b1, 1'b0);
            begin
                repeat (10) @(posedge clk);
                @(negedge clk);
                abort = 1'b1;
            end
        join
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        exp_bytes.delete();
        exp_len.delete();
        exp_id.delete();
        abort    = 1'b0;
        checking = 1'b1;
        rst <= 1'b0;
        run_round(6, 3, 9, 2, 1'b0, 1'b0);
    endtask

    // back-pressure bits from their own LFSR state
    always @(posedge clk) begin
        if (bp_on) begin
            bp_lfsr = lfsr_step(bp_lfsr);
            out_ready <= bp_lfsr[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cur_beats = 0;
        end else if (checking && out_valid && out_ready) begin
            take_output(out_beat);
        end
    end

    // follow the input selection from buffer handshakes
    always @(posedge clk) begin
        if (rst) begin
            exp_sel = 0;
        end else begin
            for (int n = 0; n < S_COUNT; n++) begin
                if (n != exp_sel && uut.buf_ready[n]) begin
                    proto_errs++;
                    $display("%s: buffer %0d got ready while input %0d is selected",
                             test_name, n, exp_sel);
                end
            end
            if (uut.buf_valid[exp_sel] && uut.buf_ready[exp_sel] &&
                uut.buf_beat[exp_sel].last) begin
                exp_sel = (exp_sel + 1) % S_COUNT;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the output stream stopped", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        for (int n = 0; n < S_COUNT; n++) begin
            in_beat[n] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        whole_word_frames();
        partial_last_beats();
        reverse_valid_order();
        random_rounds();
        reset_mid_frame();
        repeat (20) @(posedge clk);
        if (beats_seen == 0) begin
            proto_errs++;
            $display("no output beat was seen during the whole run");
        end
        $display("errors: %0d value, %0d protocol, %0d output beats checked",
                 value_errs, proto_errs, beats_seen);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/concat_pkg.sv
hdl/stream_skid_buf.sv
hdl/concat_port_seq.sv
hdl/concat_byte_repack.sv
hdl/concat_top.sv
test/concat_chk.sv
test/concat_tb.sv
